// ==== Makefile ====
# Verilator build and run of the multiply/divide testbench

VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= muldiv.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# the binary exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== muldiv.f ====
+incdir+.
muldiv_pkg.sv
muldiv_decode.sv
muldiv_multiplier.sv
muldiv_divider.sv
muldiv_hilo.sv
muldiv_top.sv
muldiv_tb.sv

// ==== muldiv_consts.svh ====
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// operand and register half width
`define MD_WORD_W 32

// width of the op code on the issue port
`define MD_OP_W 4

// cycles from issue to HI/LO update for the multiply family,
// the HI/LO register counts as the last stage
`define MD_MUL_LATENCY 5

// quotient bits, one per divider step
`define MD_DIV_STEPS 32

`endif

// ==== muldiv_decode.sv ====
`timescale 1ns/1ps

module muldiv_decode
	import muldiv_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  muldiv_op_t op,
	input  logic       flush,
	input  logic       hilo_wr,
	input  logic       hilo_wr_hi,
	input  logic       mul_done,
	input  logic       div_done,
	output logic       busy,
	output logic       mul_start,
	output logic       div_start,
	output logic       signed_op,
	output acc_mode_t  acc_mode,
	output logic       mul_commit,
	output logic       div_commit,
	output logic       move_en,
	output logic       move_hi
);

	md_state_t state;
	md_state_t state_nxt;
	acc_mode_t acc_nxt;
	logic      is_mul;
	logic      is_div;
	logic      accept;
	logic      unit_done;
	logic      discard;

	// op to unit, signedness and accumulate mode
	always_comb
	begin
		is_mul    = 1'b0;
		is_div    = 1'b0;
		signed_op = 1'b0;
		acc_nxt   = ACC_SET;
		case (op)
			MD_MULT:
			begin
				is_mul    = 1'b1;
				signed_op = 1'b1;
			end
			MD_MULTU: is_mul = 1'b1;
			MD_DIVU:  is_div = 1'b1;
			MD_DIV:
			begin
				is_div    = 1'b1;
				signed_op = 1'b1;
			end
			MD_MADDU:
			begin
				is_mul  = 1'b1;
				acc_nxt = ACC_ADD;
			end
			MD_MADD:
			begin
				is_mul    = 1'b1;
				signed_op = 1'b1;
				acc_nxt   = ACC_ADD;
			end
			MD_MSUB:
			begin
				is_mul    = 1'b1;
				signed_op = 1'b1;
				acc_nxt   = ACC_SUB;
			end
			MD_MSUBU:
			begin
				is_mul  = 1'b1;
				acc_nxt = ACC_SUB;
			end
			MD_MUL:
			begin
				is_mul    = 1'b1;
				signed_op = 1'b1;
			end
			default:
			begin
				is_mul = 1'b0;
			end
		endcase
	end

	// only an idle unit takes a new op, and never under flush
	assign accept    = start & ~flush & (state == MD_ST_IDLE) & (is_mul | is_div);
	assign mul_start = accept & is_mul;
	assign div_start = accept & is_div;
	assign busy      = accept | (state != MD_ST_IDLE);

	assign unit_done = ((state == MD_ST_MUL) & mul_done) | ((state == MD_ST_DIV) & div_done);

	always_comb
	begin
		state_nxt = state;
		case (state)
			MD_ST_IDLE:
			begin
				if (mul_start)
					state_nxt = MD_ST_MUL;
				else if (div_start)
					state_nxt = MD_ST_DIV;
			end
			MD_ST_MUL:
			begin
				if (mul_done)
					state_nxt = MD_ST_IDLE;
			end
			MD_ST_DIV:
			begin
				if (div_done)
					state_nxt = MD_ST_IDLE;
			end
			default: state_nxt = MD_ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state    <= MD_ST_IDLE;
			acc_mode <= ACC_SET;
			discard  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (mul_start)
				acc_mode <= acc_nxt;
			// a flush anywhere in flight kills the result
			if (unit_done)
				discard <= 1'b0;
			else if (flush && state != MD_ST_IDLE)
				discard <= 1'b1;
		end
	end

	// flush in the done cycle itself also blocks the commit
	assign mul_commit = (state == MD_ST_MUL) & mul_done & ~discard & ~flush;
	assign div_commit = (state == MD_ST_DIV) & div_done & ~discard & ~flush;

	assign move_en = hilo_wr & ~flush;
	assign move_hi = hilo_wr_hi;

endmodule

// ==== muldiv_divider.sv ====
`timescale 1ns/1ps

`include "muldiv_consts.svh"

module muldiv_divider
	import muldiv_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	input  logic  signed_op,
	input  word_t a,
	input  word_t b,
	output logic  done,
	output word_t quotient,
	output word_t remainder
);

	localparam int CNT_W = $clog2(`MD_DIV_STEPS);

	logic                   running;
	logic [CNT_W-1:0]       step_cnt;
	logic                   last_step;
	logic                   neg_quo;
	logic                   neg_rem;
	logic                   neg_a;
	logic                   neg_b;
	word_t                  a_mag;
	word_t                  b_mag;
	word_t                  divisor;
	word_t                  quo;
	word_t                  rem;
	logic [`MD_WORD_W:0]    shifted;
	logic [`MD_WORD_W+1:0]  diff;

	assign neg_a = signed_op & a[`MD_WORD_W-1];
	assign neg_b = signed_op & b[`MD_WORD_W-1];
	assign a_mag = neg_a ? -a : a;
	assign b_mag = neg_b ? -b : b;

	// next dividend bit enters the partial remainder, then try the subtract
	assign shifted   = {rem, quo[`MD_WORD_W-1]};
	assign diff      = {1'b0, shifted} - {2'b00, divisor};
	assign last_step = (step_cnt == CNT_W'(`MD_DIV_STEPS - 1));

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			running  <= 1'b0;
			done     <= 1'b0;
			step_cnt <= '0;
		end
		else
		begin
			done <= running & last_step;
			if (start)
			begin
				running  <= 1'b1;
				step_cnt <= '0;
			end
			else if (running)
			begin
				step_cnt <= step_cnt + 1'b1;
				if (last_step)
					running <= 1'b0;
			end
		end
	end

	// datapath, quo starts as the dividend and fills with quotient bits
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			quo     <= a_mag;
			rem     <= '0;
			divisor <= b_mag;
			neg_quo <= neg_a ^ neg_b;
			neg_rem <= neg_a;
		end
		else if (running)
		begin
			if (!diff[`MD_WORD_W+1])
			begin
				rem <= diff[`MD_WORD_W-1:0];
				quo <= {quo[`MD_WORD_W-2:0], 1'b1};
			end
			else
			begin
				rem <= shifted[`MD_WORD_W-1:0];
				quo <= {quo[`MD_WORD_W-2:0], 1'b0};
			end
		end
	end

	// divide by zero needs no special case, it falls out as all ones
	// and the dividend before this step
	assign quotient  = neg_quo ? -quo : quo;
	assign remainder = neg_rem ? -rem : rem;

endmodule

// ==== muldiv_hilo.sv ====
`timescale 1ns/1ps

module muldiv_hilo
	import muldiv_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      mul_commit,
	input  logic      div_commit,
	input  acc_mode_t acc_mode,
	input  dword_t    product,
	input  word_t     quotient,
	input  word_t     remainder,
	input  logic      move_en,
	input  logic      move_hi,
	input  word_t     move_data,
	input  logic      rd_hi,
	output word_t     hilo_out,
	output word_t     mul_out
);

	word_t  hi;
	word_t  lo;
	dword_t hilo_cur;
	dword_t hilo_acc;

	assign hilo_cur = {hi, lo};

	// fold the product into the current pair
	always_comb
	begin
		case (acc_mode)
			ACC_ADD: hilo_acc = hilo_cur + product;
			ACC_SUB: hilo_acc = hilo_cur - product;
			default: hilo_acc = product;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			hi      <= '0;
			lo      <= '0;
			mul_out <= '0;
		end
		else if (mul_commit)
		begin
			{hi, lo} <= hilo_acc;
			// MUL destination value, low word of the raw product
			mul_out  <= product[$bits(word_t)-1:0];
		end
		else if (div_commit)
		begin
			hi <= remainder;
			lo <= quotient;
		end
		else if (move_en)
		begin
			if (move_hi)
				hi <= move_data;
			else
				lo <= move_data;
		end
	end

	assign hilo_out = rd_hi ? hi : lo;

endmodule

// ==== muldiv_multiplier.sv ====
`timescale 1ns/1ps

`include "muldiv_consts.svh"

module muldiv_multiplier
	import muldiv_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   start,
	input  logic   signed_op,
	input  word_t  a,
	input  word_t  b,
	output logic   done,
	output dword_t product
);

	// HI/LO takes the final stage, so the pipe here is one short
	localparam int STAGES = `MD_MUL_LATENCY - 1;

	logic signed [2*`MD_WORD_W+1:0] prod_full;
	logic signed [`MD_WORD_W:0]     a_ext;
	logic signed [`MD_WORD_W:0]     b_ext;
	dword_t                         pipe_data [STAGES];
	logic [STAGES-1:0]              pipe_vld;

	// one extra bit makes the unsigned case a positive signed one
	assign a_ext = {signed_op & a[`MD_WORD_W-1], a};
	assign b_ext = {signed_op & b[`MD_WORD_W-1], b};

	assign prod_full = a_ext * b_ext;

	always_ff @(posedge clk)
	begin
		if (!rst)
			pipe_vld <= '0;
		else
			pipe_vld <= {pipe_vld[STAGES-2:0], start};
	end

	// payload shift stages
	always_ff @(posedge clk)
	begin
		pipe_data[0] <= prod_full[2*`MD_WORD_W-1:0];
		for (int i = 1; i < STAGES; i++)
		begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	assign done    = pipe_vld[STAGES-1];
	assign product = pipe_data[STAGES-1];

endmodule

// ==== muldiv_pkg.sv ====
`include "muldiv_consts.svh"

package muldiv_pkg;

	// one operand, HI or LO
	typedef logic [`MD_WORD_W-1:0] word_t;

	// full product, or HI:LO taken as one value
	typedef logic [2*`MD_WORD_W-1:0] dword_t;

	// op encoding as seen on the issue port
	typedef enum logic [`MD_OP_W-1:0] {
		MD_MULT  = 4'd0,
		MD_MULTU = 4'd1,
		MD_DIVU  = 4'd2,
		MD_DIV   = 4'd3,
		MD_MADDU = 4'd4,
		MD_MADD  = 4'd5,
		MD_MSUB  = 4'd6,
		MD_MSUBU = 4'd7,
		MD_MUL   = 4'd8
	} muldiv_op_t;

	// how a product is folded into HI:LO
	typedef enum logic [1:0] {
		ACC_SET,
		ACC_ADD,
		ACC_SUB
	} acc_mode_t;

	// issue sequencer, prefixed to keep clear of the op names
	typedef enum logic [1:0] {
		MD_ST_IDLE,
		MD_ST_MUL,
		MD_ST_DIV
	} md_state_t;

endpackage

// ==== muldiv_tb.sv ====
`timescale 1ns/1ps

`include "muldiv_consts.svh"

module muldiv_tb
	import muldiv_pkg::*;
;

	localparam int MUL_LAT   = `MD_MUL_LATENCY;
	localparam int DIV_LIMIT = `MD_DIV_STEPS + 16;
	localparam int W         = `MD_WORD_W;

	logic       clk;
	logic       rst;
	logic       start;
	muldiv_op_t op;
	word_t      src_a;
	word_t      src_b;
	logic       flush;
	logic       hilo_wr;
	logic       hilo_wr_hi;
	logic       hilo_rd_hi;
	logic       busy;
	word_t      hilo_out;
	word_t      mul_out;

	logic [31:0] lfsr;
	dword_t      model_hilo;
	word_t       model_mul;

	muldiv_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.op         (op),
		.src_a      (src_a),
		.src_b      (src_b),
		.flush      (flush),
		.hilo_wr    (hilo_wr),
		.hilo_wr_hi (hilo_wr_hi),
		.hilo_rd_hi (hilo_rd_hi),
		.busy       (busy),
		.hilo_out   (hilo_out),
		.mul_out    (mul_out)
	);

	always #5 clk = ~clk;

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic word_t rand_word();
		word_t w;
		for (int i = 0; i < W; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];
		end
		return w;
	endfunction

	// low 64 bits of the product of the extended operands
	function automatic dword_t product_model(word_t a, word_t b, logic sgn);
		dword_t ea;
		dword_t eb;
		ea = sgn ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
		eb = sgn ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
		return ea * eb;
	endfunction

	// truncating divide where a zero divisor gives an all ones magnitude and the dividend
	task automatic divide_model(input word_t a, input word_t b, input logic sgn,
		output word_t q, output word_t r);
		longint sa;
		longint sb;
		if (b == '0)
		begin
			q = '1;
			if (sgn && a[W-1])
				q = -q;
			r = a;
		end
		else if (sgn)
		begin
			sa = longint'($signed(a));
			sb = longint'($signed(b));
			q = word_t'(sa / sb);
			r = word_t'(sa % sb);
		end
		else
		begin
			q = a / b;
			r = a % b;
		end
	endtask

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// reads both halves and mul_out and ends one ns after the next edge
	task automatic check_state();
		hilo_rd_hi = 1'b1;
		#1;
		check_word("hi", hilo_out, model_hilo[2*W-1:W]);
		hilo_rd_hi = 1'b0;
		#1;
		check_word("lo", hilo_out, model_hilo[W-1:0]);
		check_word("mul_out", mul_out, model_mul);
		@(posedge clk);
		#1;
	endtask

	// one start cycle with busy checked while start is held
	task automatic issue(muldiv_op_t o, word_t a, word_t b, logic fl, logic exp_busy);
		op    = o;
		src_a = a;
		src_b = b;
		flush = fl;
		start = 1'b1;
		#1;
		check_bit("busy", busy, exp_busy);
		@(posedge clk);
		#1;
		start = 1'b0;
		flush = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		#1;
		while (busy)
		begin
			n++;
			if (n > DIV_LIMIT)
			begin
				$display("timeout: busy still high after %0d cycles", DIV_LIMIT);
				abort_run();
			end
			else
			begin
				@(posedge clk);
				#2;
			end
		end
		@(posedge clk);
		#1;
	endtask

	// busy must stay low for the given number of cycles
	task automatic hold_idle(int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			#1;
			check_bit("busy", busy, 1'b0);
			@(posedge clk);
			#1;
		end
	endtask

	// busy must cover exactly MUL_LAT cycles
	// a nonzero fl_cycle raises flush in that cycle
	task automatic follow_mul(int fl_cycle);
		for (int i = 1; i <= MUL_LAT; i++)
		begin
			flush = (i == fl_cycle);
			#1;
			check_bit("busy", busy, i < MUL_LAT);
			@(posedge clk);
			#1;
		end
		flush = 1'b0;
	endtask

	task automatic run_mul(muldiv_op_t o, word_t a, word_t b, int fl_cycle);
		dword_t prod;
		logic   sgn;
		sgn  = (o == MD_MULT) || (o == MD_MADD) || (o == MD_MSUB) || (o == MD_MUL);
		prod = product_model(a, b, sgn);
		issue(o, a, b, 1'b0, 1'b1);
		follow_mul(fl_cycle);
		if (fl_cycle == 0)
		begin
			case (o)
				MD_MADD, MD_MADDU: model_hilo = model_hilo + prod;
				MD_MSUB, MD_MSUBU: model_hilo = model_hilo - prod;
				default:           model_hilo = prod;
			endcase
			model_mul = prod[W-1:0];
		end
		check_state();
	endtask

	task automatic run_div(muldiv_op_t o, word_t a, word_t b, logic fl_mid);
		word_t q;
		word_t r;
		divide_model(a, b, o == MD_DIV, q, r);
		issue(o, a, b, 1'b0, 1'b1);
		if (fl_mid)
		begin
			flush = 1'b1;
			@(posedge clk);
			#1;
			flush = 1'b0;
		end
		wait_idle();
		if (!fl_mid)
			model_hilo = {r, q};
		check_state();
	endtask

	task automatic do_move(logic hi, word_t d, logic fl);
		hilo_wr    = 1'b1;
		hilo_wr_hi = hi;
		src_a      = d;
		flush      = fl;
		@(posedge clk);
		#1;
		hilo_wr = 1'b0;
		flush   = 1'b0;
		if (!fl && hi)
			model_hilo[2*W-1:W] = d;
		else if (!fl)
			model_hilo[W-1:0] = d;
		check_state();
	endtask

	task automatic reset_defaults();
		#1;
		check_bit("busy", busy, 1'b0);
		@(posedge clk);
		#1;
		check_state();
	endtask

	task automatic mult_products();
		word_t corners [5];
		word_t a;
		word_t b;
		corners[0] = 32'h0000_0000;
		corners[1] = 32'h0000_0001;
		corners[2] = 32'hffff_ffff;
		corners[3] = 32'h8000_0000;
		corners[4] = 32'h7fff_ffff;
		for (int i = 0; i < 5; i++)
		begin
			for (int j = 0; j < 5; j++)
			begin
				run_mul(MD_MULT, corners[i], corners[j], 0);
				run_mul(MD_MULTU, corners[i], corners[j], 0);
			end
		end
		for (int k = 0; k < 8; k++)
		begin
			a = rand_word();
			b = rand_word();
			run_mul(MD_MULT, a, b, 0);
			run_mul(MD_MULTU, a, b, 0);
		end
	endtask

	task automatic accumulate_ops();
		for (int k = 0; k < 6; k++)
		begin
			run_mul(MD_MADD, rand_word(), rand_word(), 0);
			run_mul(MD_MADDU, rand_word(), rand_word(), 0);
			run_mul(MD_MSUB, rand_word(), rand_word(), 0);
			run_mul(MD_MSUBU, rand_word(), rand_word(), 0);
			run_mul(MD_MUL, rand_word(), rand_word(), 0);
		end
		// wrap through zero
		run_mul(MD_MULTU, 32'h0, 32'h0, 0);
		run_mul(MD_MSUBU, 32'hffff_ffff, 32'hffff_ffff, 0);
		run_mul(MD_MADD, 32'h8000_0000, 32'h8000_0000, 0);
	endtask

	task automatic divide_ops();
		word_t da [8];
		word_t db [8];
		da[0] = 32'd7;
		db[0] = 32'hffff_fffe;
		da[1] = 32'hffff_fff9;
		db[1] = 32'd2;
		da[2] = 32'hffff_fff9;
		db[2] = 32'hffff_fffe;
		da[3] = 32'h8000_0000;
		db[3] = 32'hffff_ffff;
		da[4] = 32'd100;
		db[4] = 32'd0;
		da[5] = 32'hffff_ff9c;
		db[5] = 32'd0;
		da[6] = 32'd0;
		db[6] = 32'd5;
		da[7] = 32'hffff_ffff;
		db[7] = 32'd1;
		for (int i = 0; i < 8; i++)
		begin
			run_div(MD_DIV, da[i], db[i], 1'b0);
			run_div(MD_DIVU, da[i], db[i], 1'b0);
		end
		for (int k = 0; k < 8; k++)
		begin
			run_div(MD_DIV, rand_word(), rand_word(), 1'b0);
			// small divisor gives a wide quotient
			run_div(MD_DIVU, rand_word(), rand_word() >> 20, 1'b0);
		end
	endtask

	task automatic move_writes();
		do_move(1'b1, rand_word(), 1'b0);
		do_move(1'b0, rand_word(), 1'b0);
		do_move(1'b1, 32'hdead_0001, 1'b1);
		do_move(1'b0, 32'hdead_0002, 1'b1);
		do_move(1'b0, 32'h1234_5678, 1'b0);
	endtask

	task automatic flush_discard();
		// blocked issue
		issue(MD_MULT, rand_word(), rand_word(), 1'b1, 1'b0);
		hold_idle(MUL_LAT + 1);
		check_state();
		issue(MD_DIV, rand_word(), rand_word(), 1'b1, 1'b0);
		hold_idle(DIV_LIMIT);
		check_state();
		// discarded in flight
		run_mul(MD_MULT, rand_word(), rand_word(), 2);
		// flush in the done cycle itself
		run_mul(MD_MADDU, rand_word(), rand_word(), MUL_LAT - 1);
		run_div(MD_DIVU, rand_word(), rand_word(), 1'b1);
		// unit recovers afterwards
		run_mul(MD_MUL, rand_word(), rand_word(), 0);
		run_div(MD_DIV, rand_word(), rand_word(), 1'b0);
	endtask

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b0;
		start      = 1'b0;
		op         = MD_MULT;
		src_a      = '0;
		src_b      = '0;
		flush      = 1'b0;
		hilo_wr    = 1'b0;
		hilo_wr_hi = 1'b0;
		hilo_rd_hi = 1'b0;
		lfsr       = 32'hb66e;
		model_hilo = '0;
		model_mul  = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		reset_defaults();
		mult_products();
		accumulate_ops();
		divide_ops();
		move_writes();
		flush_discard();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== muldiv_top.sv ====
`timescale 1ns/1ps

module muldiv_top
	import muldiv_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  muldiv_op_t op,
	input  word_t      src_a,
	input  word_t      src_b,
	input  logic       flush,
	input  logic       hilo_wr,
	input  logic       hilo_wr_hi,
	input  logic       hilo_rd_hi,
	output logic       busy,
	output word_t      hilo_out,
	output word_t      mul_out
);

	logic      mul_start;
	logic      div_start;
	logic      signed_op;
	logic      mul_done;
	logic      div_done;
	logic      mul_commit;
	logic      div_commit;
	logic      move_en;
	logic      move_hi;
	acc_mode_t acc_mode;
	dword_t    product;
	word_t     quotient;
	word_t     remainder;

	muldiv_decode decode_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.op         (op),
		.flush      (flush),
		.hilo_wr    (hilo_wr),
		.hilo_wr_hi (hilo_wr_hi),
		.mul_done   (mul_done),
		.div_done   (div_done),
		.busy       (busy),
		.mul_start  (mul_start),
		.div_start  (div_start),
		.signed_op  (signed_op),
		.acc_mode   (acc_mode),
		.mul_commit (mul_commit),
		.div_commit (div_commit),
		.move_en    (move_en),
		.move_hi    (move_hi)
	);

	// operands go straight from the issue port in the accept cycle
	muldiv_multiplier mul_i (
		.clk       (clk),
		.rst       (rst),
		.start     (mul_start),
		.signed_op (signed_op),
		.a         (src_a),
		.b         (src_b),
		.done      (mul_done),
		.product   (product)
	);

	muldiv_divider div_i (
		.clk       (clk),
		.rst       (rst),
		.start     (div_start),
		.signed_op (signed_op),
		.a         (src_a),
		.b         (src_b),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	muldiv_hilo hilo_i (
		.clk        (clk),
		.rst        (rst),
		.mul_commit (mul_commit),
		.div_commit (div_commit),
		.acc_mode   (acc_mode),
		.product    (product),
		.quotient   (quotient),
		.remainder  (remainder),
		.move_en    (move_en),
		.move_hi    (move_hi),
		.move_data  (src_a),
		.rd_hi      (hilo_rd_hi),
		.hilo_out   (hilo_out),
		.mul_out    (mul_out)
	);

endmodule
